//--- Makefile
# Verilator build and run for the serial audio output

VERILATOR ?= verilator
TOP       ?= tb_i2s_audio_out
FILELIST  ?= i2s_audio_out.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SOURCES := $(shell grep '\.sv$$' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides pass or fail, grep returns non-zero without the pass line
run: build
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/100ps \
		-f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/i2s_audio_out.sv
////////////////////////////////////////////////////////////
// serial audio output top level.
// takes one stereo pair per frame from the source and sends
// it as I2S on sclk, lrck and dac, all clocked by mclk.
////////////////////////////////////////////////////////////

module i2s_audio_out #(
   parameter int MCLK_PER_SCLK = i2s_pkg::DEF_MCLK_PER_SCLK,
   parameter int SLOT_BITS     = i2s_pkg::DEF_SLOT_BITS
) (
   input  logic                  audgen_mclk,
   input  logic                  reset_n,
   input  logic                  audio_enable,
   input  i2s_pkg::sample_pair_t sample_in,
   output i2s_pkg::i2s_pins_t    pins,
   output logic                  sample_req
);

   logic               sclk;
   logic               sclk_fall;
   logic               slot_start;
   logic               lrck;
   logic               dac;
   i2s_pkg::shift_op_t shift_op;

   i2s_bit_clock #(
      .MCLK_PER_SCLK (MCLK_PER_SCLK),
      .SLOT_BITS     (SLOT_BITS)
   ) i_bit_clock (
      .audgen_mclk (audgen_mclk),
      .reset_n     (reset_n),
      .sclk        (sclk),
      .sclk_fall   (sclk_fall),
      .slot_start  (slot_start)
   );

   i2s_frame_fsm i_frame_fsm (
      .audgen_mclk  (audgen_mclk),
      .reset_n      (reset_n),
      .audio_enable (audio_enable),
      .sclk_fall    (sclk_fall),
      .slot_start   (slot_start),
      .shift_op     (shift_op),
      .lrck         (lrck),
      .sample_req   (sample_req)
   );

   i2s_sample_shifter #(
      .SLOT_BITS (SLOT_BITS)
   ) i_sample_shifter (
      .audgen_mclk (audgen_mclk),
      .reset_n     (reset_n),
      .shift_op    (shift_op),
      .sample_in   (sample_in),
      .dac         (dac)
   );

   // serial lines out as one group
   assign pins = '{sclk: sclk, lrck: lrck, dac: dac};

endmodule

//--- design/i2s_bit_clock.sv
////////////////////////////////////////////////////////////
// bit clock generator running on mclk.
// makes the sclk level plus a fall strobe one cycle ahead of
// each falling edge, and marks the wrap of the slot counter.
////////////////////////////////////////////////////////////

module i2s_bit_clock #(
   parameter int MCLK_PER_SCLK = 4,
   parameter int SLOT_BITS     = 32
) (
   input  logic audgen_mclk,
   input  logic reset_n,
   output logic sclk,
   output logic sclk_fall,
   output logic slot_start
);

   localparam int PHASE_W = (MCLK_PER_SCLK > 1) ? $clog2(MCLK_PER_SCLK) : 1;
   localparam int BIT_W   = (SLOT_BITS > 1) ? $clog2(SLOT_BITS) : 1;

   localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(MCLK_PER_SCLK - 1);
   localparam logic [PHASE_W-1:0] PHASE_HIGH = PHASE_W'(MCLK_PER_SCLK / 2);
   localparam logic [BIT_W-1:0]   BIT_LAST   = BIT_W'(SLOT_BITS - 1);

   logic [PHASE_W-1:0] phase_q;
   logic [PHASE_W-1:0] phase_next;
   logic [BIT_W-1:0]   bit_q;

   ////////////////////////////////////////////////////////////
   // mclk phase within one bit period
   ////////////////////////////////////////////////////////////

   // last phase of the period, sclk drops on the next edge
   assign sclk_fall  = (phase_q == PHASE_LAST);
   assign phase_next = sclk_fall ? '0 : phase_q + 1'b1;

   always_ff @(posedge audgen_mclk or negedge reset_n) begin
      if (!reset_n) begin
         phase_q <= '0;
         sclk    <= 1'b0;
      end else begin
         phase_q <= phase_next;
         // low for the first half of the period, high for the second
         sclk    <= (phase_next >= PHASE_HIGH);
      end
   end

   ////////////////////////////////////////////////////////////
   // bit position within the channel slot
   ////////////////////////////////////////////////////////////

   // wrap of the bit index starts the next slot
   assign slot_start = sclk_fall && (bit_q == BIT_LAST);

   always_ff @(posedge audgen_mclk or negedge reset_n) begin
      if (!reset_n) begin
         bit_q <= '0;
      end else if (sclk_fall) begin
         if (bit_q == BIT_LAST) begin
            bit_q <= '0;
         end else begin
            bit_q <= bit_q + 1'b1;
         end
      end
   end

endmodule

//--- design/i2s_frame_fsm.sv
////////////////////////////////////////////////////////////
// frame sequencer for the serial audio output.
// walks idle, left and right slots on slot starts, tells the
// shifter what to do at each bit clock fall, and drives lrck
// and the sample request strobe.
////////////////////////////////////////////////////////////

module i2s_frame_fsm (
   input  logic                audgen_mclk,
   input  logic                reset_n,
   input  logic                audio_enable,
   input  logic                sclk_fall,
   input  logic                slot_start,
   output i2s_pkg::shift_op_t  shift_op,
   output logic                lrck,
   output logic                sample_req
);

   i2s_pkg::frame_state_t state_q;
   i2s_pkg::frame_state_t state_next;

   ////////////////////////////////////////////////////////////
   // next state and shifter opcode
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_next = state_q;
      shift_op   = i2s_pkg::op_hold;

      if (slot_start) begin
         case (state_q)
            i2s_pkg::st_idle: begin
               // frames only begin on a slot boundary
               if (audio_enable) begin
                  state_next = i2s_pkg::st_left;
                  shift_op   = i2s_pkg::op_load_left;
               end else begin
                  shift_op   = i2s_pkg::op_clear;
               end
            end
            i2s_pkg::st_left: begin
               state_next = i2s_pkg::st_right;
               shift_op   = i2s_pkg::op_load_right;
            end
            i2s_pkg::st_right: begin
               // end of frame, continue or stop here
               if (audio_enable) begin
                  state_next = i2s_pkg::st_left;
                  shift_op   = i2s_pkg::op_load_left;
               end else begin
                  state_next = i2s_pkg::st_idle;
                  shift_op   = i2s_pkg::op_clear;
               end
            end
            default: begin
               state_next = i2s_pkg::st_idle;
               shift_op   = i2s_pkg::op_clear;
            end
         endcase
      end else if (sclk_fall) begin
         // mid slot, just move the word along
         if (state_q == i2s_pkg::st_idle) begin
            shift_op = i2s_pkg::op_clear;
         end else begin
            shift_op = i2s_pkg::op_shift;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // state, lrck and request registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge audgen_mclk or negedge reset_n) begin
      if (!reset_n) begin
         state_q    <= i2s_pkg::st_idle;
         lrck       <= 1'b0;
         sample_req <= 1'b0;
      end else begin
         state_q    <= state_next;
         // high only while the right slot is on the wire
         lrck       <= (state_next == i2s_pkg::st_right);
         // pair was taken at this edge, source may move on
         sample_req <= (shift_op == i2s_pkg::op_load_left);
      end
   end

endmodule

//--- design/i2s_pkg.sv
////////////////////////////////////////////////////////////
// shared types and constants for the serial audio output.
// every design file refers to these through i2s_pkg:: names,
// the top level takes its parameter defaults from here.
////////////////////////////////////////////////////////////

package i2s_pkg;

   // active bits per channel, fixes the width of the sample pair
   localparam int SAMPLE_BITS = 16;

   // defaults handed to the top level parameters
   localparam int DEF_MCLK_PER_SCLK = 4;
   localparam int DEF_SLOT_BITS     = 32;

   // one stereo sample pair, taken once per frame
   typedef struct packed {
      logic [SAMPLE_BITS-1:0] left;
      logic [SAMPLE_BITS-1:0] right;
   } sample_pair_t;

   // serial output group going to the DAC
   typedef struct packed {
      logic sclk;
      logic lrck;
      logic dac;
   } i2s_pins_t;

   typedef enum logic [1:0] {
      st_idle,
      st_left,
      st_right
   } frame_state_t;

   typedef enum logic [2:0] {
      op_hold,
      op_clear,
      op_load_left,
      op_load_right,
      op_shift
   } shift_op_t;

endpackage

//--- design/i2s_sample_shifter.sv
////////////////////////////////////////////////////////////
// data shifter for the serial audio output.
// latches the stereo pair at frame start and shifts one
// channel word out MSB first, zeros filling the slot tail.
////////////////////////////////////////////////////////////

module i2s_sample_shifter #(
   parameter int SLOT_BITS = 32
) (
   input  logic                  audgen_mclk,
   input  logic                  reset_n,
   input  i2s_pkg::shift_op_t    shift_op,
   input  i2s_pkg::sample_pair_t sample_in,
   output logic                  dac
);

   logic [i2s_pkg::SAMPLE_BITS-1:0] right_q;
   logic [SLOT_BITS-1:0]            word_q;

   // channel sample in the top bits, dummy zeros below
   function automatic logic [SLOT_BITS-1:0] align_word(
      input logic [i2s_pkg::SAMPLE_BITS-1:0] sample
   );
      logic [SLOT_BITS-1:0] w;
      w = '0;
      w[SLOT_BITS-1 -: i2s_pkg::SAMPLE_BITS] = sample;
      return w;
   endfunction

   ////////////////////////////////////////////////////////////
   // held right sample
   ////////////////////////////////////////////////////////////

   // right half of the pair waits here for its slot
   always_ff @(posedge audgen_mclk) begin
      if (shift_op == i2s_pkg::op_load_left) begin
         right_q <= sample_in.right;
      end
   end

   ////////////////////////////////////////////////////////////
   // shift word
   ////////////////////////////////////////////////////////////

   always_ff @(posedge audgen_mclk or negedge reset_n) begin
      if (!reset_n) begin
         word_q <= '0;
      end else begin
         case (shift_op)
            i2s_pkg::op_clear: begin
               word_q <= '0;
            end
            i2s_pkg::op_load_left: begin
               // left word comes straight from the input pair
               word_q <= align_word(sample_in.left);
            end
            i2s_pkg::op_load_right: begin
               word_q <= align_word(right_q);
            end
            i2s_pkg::op_shift: begin
               word_q <= {word_q[SLOT_BITS-2:0], 1'b0};
            end
            default: begin
               word_q <= word_q;
            end
         endcase
      end
   end

   // MSB is the bit currently on the line
   assign dac = word_q[SLOT_BITS-1];

endmodule

//--- i2s_audio_out.f
design/i2s_pkg.sv
design/i2s_bit_clock.sv
design/i2s_frame_fsm.sv
design/i2s_sample_shifter.sv
design/i2s_audio_out.sv
sim/tb_i2s_checks.sv
sim/tb_i2s_audio_out.sv

//--- sim/tb_i2s_audio_out.sv
////////////////////////////////////////////////////////////
// testbench for the serial audio output.
// drives reset, enable and random sample pairs, runs the
// test sequence and reports the checker's error counts.
////////////////////////////////////////////////////////////

module tb_i2s_audio_out;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_NS       = 20;
   localparam int SLOT_CYCLES  = i2s_pkg::DEF_SLOT_BITS * i2s_pkg::DEF_MCLK_PER_SCLK;
   localparam int TOTAL_FRAMES = 9;
   localparam int WATCHDOG_NS  = (TOTAL_FRAMES + 4) * 2 * SLOT_CYCLES * CLK_NS * 2;
   localparam int PAIR_W       = $bits(i2s_pkg::sample_pair_t);

   logic                  audgen_mclk;
   logic                  reset_n;
   logic                  audio_enable;
   i2s_pkg::sample_pair_t sample_in;
   i2s_pkg::i2s_pins_t    pins;
   logic                  sample_req;
   logic [31:0]           lfsr_state;
   int                    tests_passed;
   int                    tests_failed;
   int                    errors_before;

   i2s_audio_out i_dut (
      .audgen_mclk  (audgen_mclk),
      .reset_n      (reset_n),
      .audio_enable (audio_enable),
      .sample_in    (sample_in),
      .pins         (pins),
      .sample_req   (sample_req)
   );

   bind i2s_audio_out tb_i2s_checks #(
      .MCLK_PER_SCLK (MCLK_PER_SCLK),
      .SLOT_BITS     (SLOT_BITS)
   ) i_checks (
      .audgen_mclk  (audgen_mclk),
      .reset_n      (reset_n),
      .audio_enable (audio_enable),
      .sample_in    (sample_in),
      .pins         (pins),
      .sample_req   (sample_req)
   );

   initial begin
      audgen_mclk = 1'b0;
      forever #(CLK_NS / 2) audgen_mclk = ~audgen_mclk;
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_pair(output i2s_pkg::sample_pair_t p);
      logic [PAIR_W-1:0] bits;
      bits = '0;
      for (int i = 0; i < PAIR_W; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         bits       = {bits[PAIR_W-2:0], lfsr_state[0]};
      end
      p = bits;
   endtask

   // next pair goes out right after the DUT takes one
   initial begin : pair_driver
      i2s_pkg::sample_pair_t p;
      lfsr_state = 32'h9b9;
      draw_pair(p);
      sample_in = p;
      forever begin
         @(negedge audgen_mclk);
         if (sample_req) begin
            draw_pair(p);
            sample_in = p;
         end
      end
   end

   task automatic wait_requests(input int count);
      for (int n = 0; n < count; n++) begin
         @(negedge audgen_mclk);
         while (!sample_req) @(negedge audgen_mclk);
      end
   endtask

   // end of the running right slot
   task automatic wait_frame_end();
      while (!pins.lrck) @(negedge audgen_mclk);
      while (pins.lrck) @(negedge audgen_mclk);
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = i_dut.i_checks.error_count - errors_before;
      errors_before = i_dut.i_checks.error_count;
      if (errs == 0) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d check errors", name, errs);
      end
   endtask

   initial begin : main_sequence
      reset_n       = 1'b0;
      audio_enable  = 1'b0;
      tests_passed  = 0;
      tests_failed  = 0;
      errors_before = 0;

      repeat (3) @(posedge audgen_mclk);
      @(negedge audgen_mclk);
      reset_n = 1'b1;
      repeat (2) @(negedge audgen_mclk);
      end_test("1 reset");

      repeat (3 * SLOT_CYCLES) @(negedge audgen_mclk);
      end_test("2 idle");

      // the seventh request means six whole frames went out
      audio_enable = 1'b1;
      wait_requests(7);
      end_test("3 six frames");

      repeat (SLOT_CYCLES / 2) @(negedge audgen_mclk);
      audio_enable = 1'b0;
      wait_frame_end();
      repeat (2 * SLOT_CYCLES) @(negedge audgen_mclk);
      end_test("4 disable mid frame");

      audio_enable = 1'b1;
      wait_requests(2);
      repeat (SLOT_CYCLES / 2) @(negedge audgen_mclk);
      audio_enable = 1'b0;
      wait_frame_end();
      repeat (SLOT_CYCLES) @(negedge audgen_mclk);
      end_test("5 re-enable");

      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- sim/tb_i2s_checks.sv
////////////////////////////////////////////////////////////
// checker bound to the serial audio output top level.
// models bit clock, slot framing and data bits from the
// protocol rules and checks the pins with assertions.
////////////////////////////////////////////////////////////

module tb_i2s_checks #(
   parameter int MCLK_PER_SCLK = i2s_pkg::DEF_MCLK_PER_SCLK,
   parameter int SLOT_BITS     = i2s_pkg::DEF_SLOT_BITS
) (
   input logic                  audgen_mclk,
   input logic                  reset_n,
   input logic                  audio_enable,
   input i2s_pkg::sample_pair_t sample_in,
   input i2s_pkg::i2s_pins_t    pins,
   input logic                  sample_req
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int IDX_W = $clog2(i2s_pkg::SAMPLE_BITS);

   int                    error_count = 0;
   int                    phase;
   int                    bit_idx;
   i2s_pkg::frame_state_t state;
   logic                  exp_req;
   logic                  exp_sclk;
   logic                  exp_lrck;
   logic                  exp_dac;
   logic                  fall_now;
   logic                  start_now;
   logic [IDX_W-1:0]      sel;
   i2s_pkg::sample_pair_t pair_q[$];
   i2s_pkg::sample_pair_t cur_pair;

   ////////////////////////////////////////////////////////////
   // reference model of the expected line levels
   ////////////////////////////////////////////////////////////

   assign fall_now  = (phase == MCLK_PER_SCLK - 1);
   assign start_now = fall_now && (bit_idx == SLOT_BITS - 1);
   // low first half, high second half
   assign exp_sclk  = (phase >= MCLK_PER_SCLK / 2);
   assign exp_lrck  = (state == i2s_pkg::st_right);

   // msb first, zeros after the active bits
   always_comb begin
      exp_dac = 1'b0;
      sel     = IDX_W'(i2s_pkg::SAMPLE_BITS - 1 - bit_idx);
      if (bit_idx < i2s_pkg::SAMPLE_BITS) begin
         if (state == i2s_pkg::st_left) begin
            exp_dac = cur_pair.left[sel];
         end else if (state == i2s_pkg::st_right) begin
            exp_dac = cur_pair.right[sel];
         end
      end
   end

   always_ff @(posedge audgen_mclk or negedge reset_n) begin
      if (!reset_n) begin
         phase   <= 0;
         bit_idx <= 0;
         state   <= i2s_pkg::st_idle;
         exp_req <= 1'b0;
      end else begin
         phase   <= fall_now ? 0 : phase + 1;
         exp_req <= 1'b0;
         if (fall_now) begin
            bit_idx <= start_now ? 0 : bit_idx + 1;
         end
         // frames start and stop only on slot boundaries
         if (start_now) begin
            if (state == i2s_pkg::st_left) begin
               state <= i2s_pkg::st_right;
            end else if (audio_enable) begin
               state   <= i2s_pkg::st_left;
               exp_req <= 1'b1;
            end else begin
               state <= i2s_pkg::st_idle;
            end
         end
      end
   end

   // pairs in the order the source offers them
   always @(posedge audgen_mclk) begin
      if (!reset_n) begin
         pair_q.delete();
         pair_q.push_back(sample_in);
      end else if (sample_req) begin
         cur_pair <= pair_q.pop_front();
         pair_q.push_back(sample_in);
      end
   end

   ////////////////////////////////////////////////////////////
   // assertions
   ////////////////////////////////////////////////////////////

   reset_levels: assert property (
      @(posedge audgen_mclk) $rose(reset_n) |-> ({pins, sample_req} == '0)
   ) else begin
      error_count++;
      $error("FAILED {pins,sample_req}: expected 0, got %h", $sampled({pins, sample_req}));
   end

   sclk_shape: assert property (
      @(posedge audgen_mclk) disable iff (!reset_n) pins.sclk == exp_sclk
   ) else begin
      error_count++;
      $error("FAILED pins.sclk: expected %h, got %h", $sampled(exp_sclk),
             $sampled(pins.sclk));
   end

   lrck_level: assert property (
      @(posedge audgen_mclk) disable iff (!reset_n) pins.lrck == exp_lrck
   ) else begin
      error_count++;
      $error("FAILED pins.lrck: expected %h, got %h", $sampled(exp_lrck),
             $sampled(pins.lrck));
   end

   lrck_on_fall: assert property (
      @(posedge audgen_mclk) disable iff (!reset_n)
         (pins.lrck != $past(pins.lrck)) |-> (!pins.sclk && $past(pins.sclk))
   ) else begin
      error_count++;
      $error("lrck changed away from a falling sclk edge");
   end

   req_strobe: assert property (
      @(posedge audgen_mclk) disable iff (!reset_n) sample_req == exp_req
   ) else begin
      error_count++;
      $error("FAILED sample_req: expected %h, got %h", $sampled(exp_req),
             $sampled(sample_req));
   end

   dac_bits: assert property (
      @(posedge audgen_mclk) disable iff (!reset_n)
         (pins.sclk && !$past(pins.sclk)) |-> (pins.dac == exp_dac)
   ) else begin
      error_count++;
      $error("FAILED pins.dac: expected %h, got %h", $sampled(exp_dac),
             $sampled(pins.dac));
   end

endmodule
